//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_frontend -o sim_frontend

out=$(./obj_dir/sim_frontend 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

//--- tb.f
verilog/fe_pkg.sv
verilog/fe_pc_gen.sv
verilog/fe_instr_scan.sv
verilog/fe_branch_predict.sv
verilog/fe_instr_queue.sv
verilog/fe_frontend.sv
verification/tb_clk_gen.sv
verification/tb_imem.sv
verification/tb_frontend.sv

//--- verification/fetch_input.txt
# M addr data | E pc instr predicted_taken | S after_count
# R after_count is_branch taken mispredict pc target | F after_count target
M 00000080 00100093
M 00000084 00200113
M 00000088 0100006F
M 00000098 00300193
M 0000009C 00000863
M 000000A0 00400213
M 000000A4 FE009AE3
M 000000AC 00500293
M 000000B0 FEDFF06F
M 000000C0 00600313
M 000000C4 00700393
M 000000C8 00800413
M 000000CC 00900493
E 00000080 00100093 0
E 00000084 00200113 0
E 00000088 0100006F 1
E 00000098 00300193 0
E 0000009C 00000863 0
E 000000A0 00400213 0
E 000000A4 FE009AE3 1
E 00000098 00300193 0
E 0000009C 00000863 0
R 9 1 1 1 0000009C 000000AC
E 000000AC 00500293 0
E 000000B0 FEDFF06F 1
E 0000009C 00000863 1
R 12 1 0 1 0000009C 000000A0
E 000000A0 00400213 0
E 000000A4 FE009AE3 1
S 14
E 00000098 00300193 0
E 0000009C 00000863 0
E 000000A0 00400213 0
F 17 000000C0
E 000000C0 00600313 0
S 18
E 000000C4 00700393 0
E 000000C8 00800413 0
E 000000CC 00900493 0

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset low for the first two rising edges
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- verification/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    logic                 clk;
    logic                 rst_n;
    logic                 flush_i;
    fe_pkg::resolve_t     resolve_i;
    fe_pkg::mem_rsp_t     mem_rsp;
    logic                 fetch_ready_i;
    fe_pkg::mem_req_t     mem_req;
    fe_pkg::fetch_entry_t fetch_entry_o;
    logic                 fetch_valid_o;

    // expected entries
    logic [31:0]      exp_pc [$];
    logic [31:0]      exp_instr [$];
    logic             exp_taken [$];
    // events applied right after entry ev_cnt has been taken
    int               ev_kind [$];
    int               ev_cnt [$];
    fe_pkg::resolve_t ev_res [$];
    int               seed;

    tb_clk_gen i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    tb_imem i_imem (
        .clk_i  ( clk     ),
        .rst_ni ( rst_n   ),
        .req_i  ( mem_req ),
        .rsp_o  ( mem_rsp )
    );

    fe_frontend i_dut (
        .clk_i         ( clk           ),
        .rst_ni        ( rst_n         ),
        .flush_i       ( flush_i       ),
        .resolve_i     ( resolve_i     ),
        .mem_rsp_i     ( mem_rsp       ),
        .fetch_ready_i ( fetch_ready_i ),
        .mem_req_o     ( mem_req       ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o )
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // hashed addi word that is never a branch or jal
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr * 32'h9E37_79B9) ^ (addr >> 3);
        return (h & ~32'h7F) | 32'h13;
    endfunction

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_entry(input int idx);
        assert (fetch_entry_o.pc == exp_pc[idx]) else begin
            $display("Fail %0t fetch_entry_o.pc got %h expected %h",
                     $time, fetch_entry_o.pc, exp_pc[idx]);
            stop_with_failure();
        end
        assert (fetch_entry_o.instr == exp_instr[idx]) else begin
            $display("Fail %0t fetch_entry_o.instr got %h expected %h",
                     $time, fetch_entry_o.instr, exp_instr[idx]);
            stop_with_failure();
        end
        assert (fetch_entry_o.predicted_taken == exp_taken[idx]) else begin
            $display("Fail %0t fetch_entry_o.predicted_taken got %b expected %b",
                     $time, fetch_entry_o.predicted_taken, exp_taken[idx]);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // data file
    // ------------------------------------------------------------------------
    task automatic read_input_file();
        int               fd;
        string            line;
        int               kind;
        int               cnt;
        logic [31:0]      a;
        logic [31:0]      d;
        int               n;
        int               n_exp;
        int               b0;
        int               b1;
        int               b2;
        fe_pkg::resolve_t res;
        fd = $fopen("verification/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            stop_with_failure();
        end
        while ($fgets(line, fd) > 0) begin
            kind  = 0;
            n     = 0;
            n_exp = 0;
            res   = '0;
            if (line.len() >= 2 && line.getc(0) != "#") begin
                kind = line.getc(0);
            end
            if (kind == "M") begin
                n_exp = 3;
                n = $sscanf(line, "%c %h %h", kind, a, d);
                i_imem.mem[a[9:2]] = d;
            end else if (kind == "E") begin
                n_exp = 4;
                n = $sscanf(line, "%c %h %h %d", kind, a, d, b0);
                exp_pc.push_back(a);
                exp_instr.push_back(d);
                exp_taken.push_back(b0 != 0);
            end else if (kind == "R") begin
                n_exp = 7;
                n = $sscanf(line, "%c %d %d %d %d %h %h", kind, cnt, b0, b1, b2, a, d);
                res.valid      = 1'b1;
                res.is_branch  = (b0 != 0);
                res.taken      = (b1 != 0);
                res.mispredict = (b2 != 0);
                res.pc         = a;
                res.target     = d;
            end else if (kind == "F") begin
                n_exp = 3;
                n = $sscanf(line, "%c %d %h", kind, cnt, d);
                // flush carries only the target
                res.target = d;
            end else if (kind == "S") begin
                n_exp = 2;
                n = $sscanf(line, "%c %d", kind, cnt);
            end
            if (n != n_exp) begin
                $display("malformed line in the stimulus file");
                stop_with_failure();
            end
            if (kind == "R" || kind == "F" || kind == "S") begin
                ev_kind.push_back(kind);
                ev_cnt.push_back(cnt);
                ev_res.push_back(res);
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // stimulus and checking
    // ------------------------------------------------------------------------
    initial begin : main
        int          n_got;
        int          ev_idx;
        int          idle;
        int          stall_left;
        logic        take;
        logic        exp_kill;
        logic        req_due;
        logic [31:0] exp_target;
        n_got      = 0;
        ev_idx     = 0;
        idle       = 0;
        stall_left = 0;
        exp_kill   = 1'b0;
        req_due    = 1'b0;
        exp_target = '0;
        seed       = 3;
        flush_i       = 1'b0;
        resolve_i     = '0;
        fetch_ready_i = 1'b1;
        // background fill first so listed words land on top
        for (int i = 0; i < 256; i++) begin
            i_imem.mem[i] = fill_word(32'(i) << 2);
        end
        read_input_file();

        while (n_got < exp_pc.size()) begin
            // outputs are settled at the falling edge
            @(negedge clk);
            take = fetch_valid_o && fetch_ready_i;
            // kill only in the cycle of a redirect
            assert (mem_req.kill == exp_kill) else begin
                $display("Fail %0t mem_req_o.kill got %b expected %b",
                         $time, mem_req.kill, exp_kill);
                stop_with_failure();
            end
            // fetch restarts at the target in the cycle after the redirect
            if (req_due) begin
                assert (mem_req.req == 1'b1) else begin
                    $display("Fail %0t mem_req_o.req got %b expected %b",
                             $time, mem_req.req, 1'b1);
                    stop_with_failure();
                end
                assert (mem_req.addr == exp_target) else begin
                    $display("Fail %0t mem_req_o.addr got %h expected %h",
                             $time, mem_req.addr, exp_target);
                    stop_with_failure();
                end
            end
            if (take) begin
                check_entry(n_got);
                n_got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > 200) begin
                    $display("no entry came out of the frontend in time");
                    stop_with_failure();
                end
            end
            @(posedge clk);
            req_due   = exp_kill;
            exp_kill  = 1'b0;
            resolve_i <= '0;
            flush_i   <= 1'b0;
            if (stall_left > 0) begin
                fetch_ready_i <= 1'b0;
                stall_left--;
            end else begin
                fetch_ready_i <= 1'b1;
            end
            while (take && ev_idx < ev_kind.size() && ev_cnt[ev_idx] == n_got) begin
                if (ev_kind[ev_idx] == "S") begin
                    fetch_ready_i <= 1'b0;
                    stall_left = 9 + int'($unsigned($random(seed)) % 20);
                end else begin
                    // stale queue entries must not be taken in the redirect cycle
                    resolve_i     <= ev_res[ev_idx];
                    flush_i       <= (ev_kind[ev_idx] == "F");
                    fetch_ready_i <= 1'b0;
                    exp_kill      = (ev_kind[ev_idx] == "F") || ev_res[ev_idx].mispredict;
                    exp_target    = ev_res[ev_idx].target;
                end
                ev_idx++;
            end
        end

        if (ev_idx == ev_kind.size() && n_got > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("entries or events of the stimulus file were left unused");
            stop_with_failure();
        end
    end

endmodule

//--- verification/tb_imem.sv
`timescale 1ns/1ps

module tb_imem (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  fe_pkg::mem_req_t req_i,
    output fe_pkg::mem_rsp_t rsp_o
);

    // word array, loaded by the testbench top
    logic [31:0] mem [256];

    int          seed;
    logic        busy_q;
    int          wait_q;
    logic [31:0] addr_q;

    initial seed = 3;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            wait_q <= 0;
            addr_q <= '0;
            rsp_o  <= '0;
        end else begin
            rsp_o.ready <= 1'b1;
            rsp_o.valid <= 1'b0;
            if (req_i.kill) begin
                // killed fetch gets no answer
                busy_q <= 1'b0;
            end else if (busy_q) begin
                if (wait_q == 1) begin
                    rsp_o.valid <= 1'b1;
                    rsp_o.data  <= mem[addr_q[9:2]];
                    rsp_o.addr  <= addr_q;
                    busy_q      <= 1'b0;
                end else begin
                    wait_q <= wait_q - 1;
                end
            end else if (req_i.req && rsp_o.ready) begin
                busy_q <= 1'b1;
                addr_q <= req_i.addr;
                // latency of 1 to 3 cycles
                wait_q <= int'($unsigned($random(seed)) % 3) + 1;
            end
        end
    end

endmodule

//--- verilog/fe_branch_predict.sv
`timescale 1ns/1ps

module fe_branch_predict (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    input  logic [fe_pkg::XLEN-1:0] pc_i,
    input  fe_pkg::scan_t           scan_i,
    input  fe_pkg::resolve_t        resolve_i,
    output fe_pkg::prediction_t     predict_o
);

    // bht storage, one valid bit and one 2-bit counter per entry
    logic [fe_pkg::BHT_ENTRIES-1:0] bht_valid_q;
    logic [1:0]                     bht_cnt_q [fe_pkg::BHT_ENTRIES];

    logic [fe_pkg::BHT_IDX_W-1:0]   rd_idx;
    logic [fe_pkg::BHT_IDX_W-1:0]   upd_idx;
    logic                           upd_en;
    logic [1:0]                     cnt_cur;
    logic [1:0]                     cnt_next;
    logic                           branch_taken;

    // ------------------------------------------------------------------------
    // update from the resolve port
    // ------------------------------------------------------------------------
    assign upd_en  = resolve_i.valid & resolve_i.is_branch;
    assign upd_idx = resolve_i.pc[fe_pkg::BHT_IDX_W+1:2];
    assign cnt_cur = bht_cnt_q[upd_idx];

    always_comb begin
        cnt_next = cnt_cur;
        if (!bht_valid_q[upd_idx]) begin
            // first outcome seeds a weak counter
            cnt_next = resolve_i.taken ? 2'd2 : 2'd1;
        end else if (resolve_i.taken) begin
            if (cnt_cur != 2'd3) begin
                cnt_next = cnt_cur + 2'd1;
            end
        end else if (cnt_cur != 2'd0) begin
            cnt_next = cnt_cur - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bht_valid_q <= '0;
        end else if (upd_en) begin
            bht_valid_q[upd_idx] <= 1'b1;
        end
    end

    // counters only count once their valid bit is set
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            bht_cnt_q[upd_idx] <= cnt_next;
        end
    end

    // ------------------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------------------
    assign rd_idx = pc_i[fe_pkg::BHT_IDX_W+1:2];

    always_comb begin
        if (bht_valid_q[rd_idx]) begin
            // weakly or strongly taken
            branch_taken = bht_cnt_q[rd_idx][1];
        end else begin
            // static fallback, backward branches are loops
            branch_taken = scan_i.imm[fe_pkg::XLEN-1];
        end
        predict_o.taken  = valid_i & (scan_i.is_jal | (scan_i.is_branch & branch_taken));
        predict_o.target = pc_i + scan_i.imm;
    end

    // scan must hand over at most one kind of control flow per word
    a_one_cf_kind : assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> !(scan_i.is_branch && scan_i.is_jal))
        else $error("branch and jal decoded for the same word");

endmodule

//--- verilog/fe_frontend.sv
`timescale 1ns/1ps

module fe_frontend (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  fe_pkg::resolve_t     resolve_i,
    input  fe_pkg::mem_rsp_t     mem_rsp_i,
    input  logic                 fetch_ready_i,
    output fe_pkg::mem_req_t     mem_req_o,
    output fe_pkg::fetch_entry_t fetch_entry_o,
    output logic                 fetch_valid_o
);

    logic                    redirect;
    logic [fe_pkg::XLEN-1:0] redirect_pc;
    logic                    queue_full;
    logic                    rsp_valid;
    logic [fe_pkg::XLEN-1:0] rsp_word;
    logic [fe_pkg::XLEN-1:0] rsp_pc;
    fe_pkg::scan_t           scan;
    fe_pkg::prediction_t     prediction;
    fe_pkg::fetch_entry_t    entry;

    // ------------------------------------------------------------------------
    // redirect on a mispredict or a frontend flush, both go to target
    // ------------------------------------------------------------------------
    assign redirect    = flush_i | (resolve_i.valid & resolve_i.mispredict);
    assign redirect_pc = resolve_i.target;

    // word pushed together with its prediction
    assign entry.pc              = rsp_pc;
    assign entry.instr           = rsp_word;
    assign entry.predicted_taken = prediction.taken;

    // input side
    fe_pc_gen i_pc_gen (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .redirect_i    ( redirect    ),
        .redirect_pc_i ( redirect_pc ),
        .predict_i     ( prediction  ),
        .queue_full_i  ( queue_full  ),
        .mem_rsp_i     ( mem_rsp_i   ),
        .mem_req_o     ( mem_req_o   ),
        .rsp_valid_o   ( rsp_valid   ),
        .rsp_word_o    ( rsp_word    ),
        .rsp_pc_o      ( rsp_pc      )
    );

    // processing, scan then predict in the same cycle
    fe_instr_scan i_instr_scan (
        .instr_i ( rsp_word ),
        .scan_o  ( scan     )
    );

    fe_branch_predict i_branch_predict (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .valid_i   ( rsp_valid  ),
        .pc_i      ( rsp_pc     ),
        .scan_i    ( scan       ),
        .resolve_i ( resolve_i  ),
        .predict_o ( prediction )
    );

    // output side towards decode
    fe_instr_queue i_instr_queue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( redirect      ),
        .push_i        ( rsp_valid     ),
        .entry_i       ( entry         ),
        .fetch_ready_i ( fetch_ready_i ),
        .full_o        ( queue_full    ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o )
    );

endmodule

//--- verilog/fe_instr_queue.sv
`timescale 1ns/1ps

module fe_instr_queue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  fe_pkg::fetch_entry_t entry_i,
    input  logic                 fetch_ready_i,
    output logic                 full_o,
    output fe_pkg::fetch_entry_t fetch_entry_o,
    output logic                 fetch_valid_o
);

    // entry storage
    fe_pkg::fetch_entry_t mem_q [fe_pkg::QUEUE_DEPTH];

    logic [$clog2(fe_pkg::QUEUE_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(fe_pkg::QUEUE_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(fe_pkg::QUEUE_DEPTH):0]   count_q;
    logic                                   do_push;
    logic                                   do_pop;

    // ------------------------------------------------------------------------
    // status and handshake
    // ------------------------------------------------------------------------
    assign full_o        = (count_q == fe_pkg::QUEUE_DEPTH);
    assign fetch_valid_o = (count_q != '0);
    assign fetch_entry_o = mem_q[rd_ptr_q];

    // a flush discards the incoming word too
    assign do_push = push_i & ~flush_i & ~full_o;
    assign do_pop  = fetch_valid_o & fetch_ready_i & ~flush_i;

    // ------------------------------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // wrap explicitly so any depth works
                if (wr_ptr_q == fe_pkg::QUEUE_DEPTH - 1) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr_q == fe_pkg::QUEUE_DEPTH - 1) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // push and pop together keep the level
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // fetch side holds requests back while full, so no word is ever dropped
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && !flush_i |-> !full_o)
        else $error("push into a full instruction queue");

endmodule

//--- verilog/fe_instr_scan.sv
`timescale 1ns/1ps

module fe_instr_scan (
    input  logic [fe_pkg::XLEN-1:0] instr_i,
    output fe_pkg::scan_t           scan_o
);

    fe_pkg::instr_u word;
    logic [fe_pkg::XLEN-1:0] b_imm;
    logic [fe_pkg::XLEN-1:0] j_imm;

    assign word = instr_i;

    // ------------------------------------------------------------------------
    // immediates from both views
    // ------------------------------------------------------------------------
    // b-type offset, bit 0 is always zero
    assign b_imm = {
        {19{word.b.imm12}},
        word.b.imm12,
        word.b.imm11,
        word.b.imm10_5,
        word.b.imm4_1,
        1'b0
    };

    // j-type offset, 21 bits before extension
    assign j_imm = {
        {11{word.j.imm20}},
        word.j.imm20,
        word.j.imm19_12,
        word.j.imm11,
        word.j.imm10_1,
        1'b0
    };

    // ------------------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------------------
    always_comb begin
        scan_o.is_branch = (word.b.opcode == fe_pkg::OPC_BRANCH);
        scan_o.is_jal    = (word.j.opcode == fe_pkg::OPC_JAL);
        if (scan_o.is_branch) begin
            scan_o.imm = b_imm;
        end else if (scan_o.is_jal) begin
            scan_o.imm = j_imm;
        end else begin
            // not a control flow instruction
            scan_o.imm = '0;
        end
    end

endmodule

//--- verilog/fe_pc_gen.sv
`timescale 1ns/1ps

module fe_pc_gen (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    redirect_i,
    input  logic [fe_pkg::XLEN-1:0] redirect_pc_i,
    input  fe_pkg::prediction_t     predict_i,
    input  logic                    queue_full_i,
    input  fe_pkg::mem_rsp_t        mem_rsp_i,
    output fe_pkg::mem_req_t        mem_req_o,
    output logic                    rsp_valid_o,
    output logic [fe_pkg::XLEN-1:0] rsp_word_o,
    output logic [fe_pkg::XLEN-1:0] rsp_pc_o
);

    // address of the next fetch
    logic [fe_pkg::XLEN-1:0] pc_q;
    logic [fe_pkg::XLEN-1:0] pc_d;
    // low while still in reset, high from the first edge on
    logic                    run_q;
    logic                    outstanding_q;
    logic                    accept;
    // registered memory response
    logic                    rsp_valid_q;
    logic [fe_pkg::XLEN-1:0] rsp_word_q;
    logic [fe_pkg::XLEN-1:0] rsp_pc_q;

    // ------------------------------------------------------------------------
    // memory request
    // ------------------------------------------------------------------------
    // only one fetch in flight, and none while the queue has no room
    assign mem_req_o.req  = run_q & ~outstanding_q & ~queue_full_i & ~redirect_i;
    assign mem_req_o.kill = redirect_i;
    assign mem_req_o.addr = pc_q;
    assign accept         = mem_req_o.req & mem_rsp_i.ready;

    // ------------------------------------------------------------------------
    // next pc
    // ------------------------------------------------------------------------
    always_comb begin
        pc_d = pc_q;
        // redirect beats prediction, prediction beats sequential
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (rsp_valid_q) begin
            pc_d = predict_i.taken ? predict_i.target : rsp_pc_q + fe_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q          <= fe_pkg::BOOT_ADDR;
            run_q         <= 1'b0;
            outstanding_q <= 1'b0;
            rsp_valid_q   <= 1'b0;
        end else begin
            run_q       <= 1'b1;
            pc_q        <= pc_d;
            // a response for a killed fetch never reaches the queue
            rsp_valid_q <= mem_rsp_i.valid & outstanding_q & ~redirect_i;
            if (redirect_i) begin
                outstanding_q <= 1'b0;
            end else if (accept) begin
                outstanding_q <= 1'b1;
            end else if (rsp_valid_q) begin
                // released once the word has been pushed
                outstanding_q <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk_i) begin
        if (mem_rsp_i.valid) begin
            rsp_word_q <= mem_rsp_i.data;
            rsp_pc_q   <= mem_rsp_i.addr;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_word_o  = rsp_word_q;
    assign rsp_pc_o    = rsp_pc_q;

    // fetch addresses stay word aligned even after a redirect
    a_pc_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req |-> mem_req_o.addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // the memory only answers a fetch in flight, so no new request may be up then
    a_single_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_i.valid |-> !mem_req_o.req)
        else $error("second request raised while one is outstanding");

endmodule

//--- verilog/fe_pkg.sv
package fe_pkg;

    // ------------------------------------------------------------------------
    // widths, addresses and opcodes
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN        = 32;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_0080;
    localparam int unsigned BHT_ENTRIES = 16;
    // bht index comes from pc[5:2]
    localparam int unsigned BHT_IDX_W   = 4;
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam logic [6:0]  OPC_BRANCH  = 7'b110_0011;
    localparam logic [6:0]  OPC_JAL     = 7'b110_1111;

    // ------------------------------------------------------------------------
    // instruction memory handshake
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic            req;
        logic            kill;   // drop the request in flight
        logic [XLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic            ready;
        logic            valid;  // one cycle pulse per answered request
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] addr;
    } mem_rsp_t;

    // branch outcome reported by the backend
    typedef struct packed {
        logic            valid;
        logic            is_branch;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
    } resolve_t;

    // ------------------------------------------------------------------------
    // scan, prediction and queue entries
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic            is_branch;
        logic            is_jal;
        logic [XLEN-1:0] imm;    // already sign extended
    } scan_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } prediction_t;

    // successor of a taken entry is its target, so no target field
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            predicted_taken;
    } fetch_entry_t;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, two field views
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } instr_u;

endpackage
